// ==== design/rv32i_mem_consts.svh ====
`ifndef RV32I_MEM_CONSTS_SVH
`define RV32I_MEM_CONSTS_SVH

// major opcodes seen by the memory stage
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// load widths
`define F3_LB     3'b000
`define F3_LH     3'b001
`define F3_LW     3'b010
`define F3_LBU    3'b100
`define F3_LHU    3'b101

// store widths
`define F3_SB     3'b000
`define F3_SH     3'b001
`define F3_SW     3'b010

// data sram geometry, words and word-index bits
`define DMEM_WORDS 256
`define DMEM_AW    8

`endif

// ==== design/rv32i_types_pkg.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

package rv32i_types;

    // data or address word
    typedef logic [31:0] rv32i_word;

    // raw opcode field
    typedef logic [6:0] rv32i_opcode_t;

    // architectural register index
    typedef logic [4:0] rv32i_reg_t;

    // one bit per byte lane, bit k is byte k
    typedef logic [3:0] byte_mask_t;

    // byte offset inside a word
    typedef logic [1:0] lane_t;

    // funct3 before interpretation
    typedef logic [2:0] funct3_t;

    // load width and signedness
    typedef enum logic [2:0] {
        lb  = `F3_LB,
        lh  = `F3_LH,
        lw  = `F3_LW,
        lbu = `F3_LBU,
        lhu = `F3_LHU
    } load_funct3_t;

    // store width
    typedef enum logic [2:0] {
        sb = `F3_SB,
        sh = `F3_SH,
        sw = `F3_SW
    } store_funct3_t;

endpackage

`default_nettype wire

// ==== design/dmem_if.sv ====
`default_nettype none

interface dmem_if
import rv32i_types::*;
();

    // word-aligned request address
    rv32i_word  address;
    rv32i_word  wdata;
    // lanes touched by this access
    byte_mask_t byte_enable;
    // single-cycle strobes, mutually exclusive
    logic       read;
    logic       write;
    // valid in the cycle after a read strobe
    rv32i_word  rdata;

    // stage side
    modport requester (
        output address, wdata, byte_enable, read, write,
        input  rdata
    );

    // memory side
    modport responder (
        input  address, wdata, byte_enable, read, write,
        output rdata
    );

endinterface

`default_nettype wire

// ==== design/mem_stage.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

module mem_stage
import rv32i_types::*;
(
    // ex/mem record
    input  logic          valid,
    input  rv32i_opcode_t opcode,
    input  funct3_t       funct3,
    input  rv32i_word     alu_out,
    input  rv32i_word     store_data,

    // fields carried on to the mem/wb register
    output rv32i_word     mem_addr,
    output byte_mask_t    rmask,
    output byte_mask_t    wmask,
    output rv32i_word     st_wdata,
    output logic          trap,

    // request to the data sram
    dmem_if.requester     dmem
);

    logic          is_load;
    logic          is_store;
    lane_t         lane;
    byte_mask_t    lane_mask;
    logic          misaligned;
    load_funct3_t  load_funct3;
    store_funct3_t store_funct3;

    // only a valid record can touch memory
    assign is_load  = valid && (opcode == `OP_LOAD);
    assign is_store = valid && (opcode == `OP_STORE);

    assign load_funct3  = load_funct3_t'(funct3);
    assign store_funct3 = store_funct3_t'(funct3);

    // byte offset from the low address bits
    assign lane     = alu_out[1:0];
    assign mem_addr = {alu_out[31:2], 2'b00};

    // width mask moved onto the lane, plus alignment check
    always_comb begin
        lane_mask  = '0;
        misaligned = 1'b0;
        if (is_load) begin
            case (load_funct3)
                lb, lbu: lane_mask = 4'b0001 << lane;
                lh, lhu: begin
                    lane_mask  = 4'b0011 << lane;
                    // halfword must start at lane 0 or 2
                    misaligned = lane[0];
                end
                lw: begin
                    lane_mask  = 4'b1111;
                    misaligned = |lane;
                end
                default: ;
            endcase
        end else if (is_store) begin
            case (store_funct3)
                sb: lane_mask = 4'b0001 << lane;
                sh: begin
                    lane_mask  = 4'b0011 << lane;
                    misaligned = lane[0];
                end
                sw: begin
                    lane_mask  = 4'b1111;
                    misaligned = |lane;
                end
                default: ;
            endcase
        end
    end

    // misaligned access squashed, masks forced to zero
    assign trap  = misaligned;
    assign rmask = (is_load && !misaligned) ? lane_mask : '0;
    assign wmask = (is_store && !misaligned) ? lane_mask : '0;

    // store data lands on its own lanes
    assign st_wdata = store_data << {lane, 3'b000};

    // strobes follow the masks, so a trap raises neither
    assign dmem.address     = mem_addr;
    assign dmem.wdata       = st_wdata;
    assign dmem.byte_enable = rmask | wmask;
    assign dmem.read        = |rmask;
    assign dmem.write       = |wmask;

endmodule

`default_nettype wire

// ==== design/data_sram.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

module data_sram
import rv32i_types::*;
(
    input  logic       clk,

    // request from the memory stage
    dmem_if.responder  dmem
);

    // word storage
    rv32i_word mem [`DMEM_WORDS];

    // word index, address wraps at the depth
    logic [`DMEM_AW-1:0] word_idx;

    assign word_idx = dmem.address[`DMEM_AW+1:2];

    // memory starts cleared
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte-lane write, only enabled lanes change
    always_ff @(posedge clk) begin
        if (dmem.write) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem.byte_enable[k]) begin
                    mem[word_idx][8*k +: 8] <= dmem.wdata[8*k +: 8];
                end
            end
        end
    end

    // read data registered, stays put until the next read
    always_ff @(posedge clk) begin
        if (dmem.read) begin
            dmem.rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_wb_reg.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

module mem_wb_reg
import rv32i_types::*;
(
    input  logic          clk,
    input  logic          rst,

    // record leaving mem
    input  logic          valid,
    input  rv32i_opcode_t opcode,
    input  funct3_t       funct3,
    input  rv32i_reg_t    rd,
    input  rv32i_word     alu_out,
    input  rv32i_word     mem_addr,
    input  byte_mask_t    rmask,
    input  byte_mask_t    wmask,
    input  rv32i_word     st_wdata,
    input  logic          trap,

    // record in wb
    output logic          wb_valid,
    output rv32i_opcode_t wb_opcode,
    output funct3_t       wb_funct3,
    output rv32i_reg_t    wb_rd,
    output rv32i_word     wb_alu_out,
    output rv32i_word     wb_mem_addr,
    output byte_mask_t    wb_rmask,
    output byte_mask_t    wb_wmask,
    output rv32i_word     wb_st_wdata,
    output logic          wb_trap,
    output logic          wb_rd_we
);

    // control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_trap  <= 1'b0;
        end else begin
            wb_valid <= valid;
            wb_trap  <= trap;
        end
    end

    // payload and rvfi memory fields
    always_ff @(posedge clk) begin
        wb_opcode   <= opcode;
        wb_funct3   <= funct3;
        wb_rd       <= rd;
        wb_alu_out  <= alu_out;
        wb_mem_addr <= mem_addr;
        wb_rmask    <= rmask;
        wb_wmask    <= wmask;
        wb_st_wdata <= st_wdata;
    end

    // regfile write: stores and traps never write, x0 never written
    assign wb_rd_we = wb_valid && !wb_trap && (wb_opcode != `OP_STORE) && (wb_rd != '0);

endmodule

`default_nettype wire

// ==== design/load_align.sv ====
`default_nettype none

module load_align
import rv32i_types::*;
(
    input  logic      is_load,
    input  funct3_t   funct3,
    // byte offset of the original address
    input  lane_t     lane,
    input  rv32i_word alu_result,
    // raw word from the sram
    input  rv32i_word rdata,

    output rv32i_word wb_data
);

    rv32i_word    shifted;
    load_funct3_t load_funct3;

    assign load_funct3 = load_funct3_t'(funct3);

    // addressed byte or halfword moved down to bit 0
    assign shifted = rdata >> {lane, 3'b000};

    always_comb begin
        // non-loads write back the alu result
        wb_data = alu_result;
        if (is_load) begin
            case (load_funct3)
                lb:  wb_data = {{24{shifted[7]}}, shifted[7:0]};
                lbu: wb_data = {24'b0, shifted[7:0]};
                lh:  wb_data = {{16{shifted[15]}}, shifted[15:0]};
                lhu: wb_data = {16'b0, shifted[15:0]};
                lw:  wb_data = rdata;
                // undefined width, hand back the raw word
                default: wb_data = rdata;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

module mem_subsys_top
import rv32i_types::*;
(
    input  logic          clk,
    input  logic          rst,

    // ex/mem record
    input  logic          in_valid,
    input  rv32i_opcode_t opcode,
    input  funct3_t       funct3,
    input  rv32i_word     alu_out,
    input  rv32i_word     store_data,
    input  rv32i_reg_t    rd,

    // write-back and rvfi memory view
    output logic          wb_valid,
    output rv32i_reg_t    wb_rd,
    output logic          wb_rd_we,
    output rv32i_word     wb_data,
    output rv32i_word     wb_addr,
    output byte_mask_t    wb_rmask,
    output byte_mask_t    wb_wmask,
    output rv32i_word     wb_mem_wdata,
    output logic          wb_trap
);

    // mem stage outputs
    rv32i_word     mem_addr;
    byte_mask_t    rmask;
    byte_mask_t    wmask;
    rv32i_word     st_wdata;
    logic          trap;

    // registered fields used only inside
    rv32i_opcode_t wb_opcode;
    funct3_t       wb_funct3;
    rv32i_word     wb_alu_out;

    // stage to sram
    dmem_if dmem_bus ();

    mem_stage u_mem_stage (
        .valid      (in_valid),
        .opcode     (opcode),
        .funct3     (funct3),
        .alu_out    (alu_out),
        .store_data (store_data),
        .mem_addr   (mem_addr),
        .rmask      (rmask),
        .wmask      (wmask),
        .st_wdata   (st_wdata),
        .trap       (trap),
        .dmem       (dmem_bus.requester)
    );

    data_sram u_data_sram (
        .clk  (clk),
        .dmem (dmem_bus.responder)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk         (clk),
        .rst         (rst),
        .valid       (in_valid),
        .opcode      (opcode),
        .funct3      (funct3),
        .rd          (rd),
        .alu_out     (alu_out),
        .mem_addr    (mem_addr),
        .rmask       (rmask),
        .wmask       (wmask),
        .st_wdata    (st_wdata),
        .trap        (trap),
        .wb_valid    (wb_valid),
        .wb_opcode   (wb_opcode),
        .wb_funct3   (wb_funct3),
        .wb_rd       (wb_rd),
        .wb_alu_out  (wb_alu_out),
        .wb_mem_addr (wb_addr),
        .wb_rmask    (wb_rmask),
        .wb_wmask    (wb_wmask),
        .wb_st_wdata (wb_mem_wdata),
        .wb_trap     (wb_trap),
        .wb_rd_we    (wb_rd_we)
    );

    // lane comes from the unaligned address kept in alu_out
    load_align u_load_align (
        .is_load    (wb_opcode == `OP_LOAD),
        .funct3     (wb_funct3),
        .lane       (wb_alu_out[1:0]),
        .alu_result (wb_alu_out),
        .rdata      (dmem_bus.rdata),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== tb/mem_subsys_chk.sv ====
`default_nettype none

module mem_subsys_chk (
    input logic       clk,
    input logic       rst,
    input logic       in_valid,
    input logic       dmem_read,
    input logic       dmem_write,
    input logic       trap,
    input logic       wb_valid,
    input logic [3:0] wb_rmask,
    input logic [3:0] wb_wmask
);

    timeunit 1ns;
    timeprecision 1ps;

    // strobes are exclusive on the sram bus
    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write))
        else $error("dmem read and write high in the same cycle");

    // a trapped access never reaches the sram
    a_trap_quiet: assert property (@(posedge clk) disable iff (rst)
        trap |-> (!dmem_read && !dmem_write))
        else $error("strobe raised on a trapped access");

    // one cycle from ex/mem to wb
    a_valid_lat: assert property (@(posedge clk) disable iff (rst)
        wb_valid == $past(in_valid))
        else $error("wb_valid does not follow in_valid by one cycle");

    // an access is a load or a store, not both
    a_mask_excl: assert property (@(posedge clk) disable iff (rst)
        !((|wb_rmask) && (|wb_wmask)))
        else $error("wb_rmask and wb_wmask both nonzero");

endmodule

`default_nettype wire

// ==== tb/mem_subsys_tb.sv ====
`default_nettype none

`include "rv32i_mem_consts.svh"

module mem_subsys_tb
import rv32i_types::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int MEM_BYTES    = `DMEM_WORDS * 4;

    logic          clk = 1'b0;
    logic          rst;
    logic          in_valid;
    rv32i_opcode_t opcode;
    funct3_t       funct3;
    rv32i_word     alu_out;
    rv32i_word     store_data;
    rv32i_reg_t    rd;

    logic          wb_valid;
    rv32i_reg_t    wb_rd;
    logic          wb_rd_we;
    rv32i_word     wb_data;
    rv32i_word     wb_addr;
    byte_mask_t    wb_rmask;
    byte_mask_t    wb_wmask;
    rv32i_word     wb_mem_wdata;
    logic          wb_trap;

    // stimulus table with one entry per cycle
    string         t_name [$];
    rv32i_opcode_t t_op [$];
    funct3_t       t_f3 [$];
    rv32i_word     t_addr [$];
    rv32i_word     t_data [$];
    rv32i_reg_t    t_rd [$];

    // byte-level image of the sram
    logic [7:0]    mem_model [MEM_BYTES];
    logic [7:0]    lane_bytes [4] = '{8'h81, 8'h7f, 8'hc3, 8'h05};

    int            cycles = 0;
    int            cycle_limit = 0;

    mem_subsys_top uut (.*);

    bind mem_subsys_top mem_subsys_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .dmem_read  (dmem_bus.read),
        .dmem_write (dmem_bus.write),
        .trap       (trap),
        .wb_valid   (wb_valid),
        .wb_rmask   (wb_rmask),
        .wb_wmask   (wb_wmask)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic add_row(input string name, input rv32i_opcode_t op, input funct3_t f3,
                           input rv32i_word addr, input rv32i_word data,
                           input rv32i_reg_t rd_idx);
        t_name.push_back(name);
        t_op.push_back(op);
        t_f3.push_back(f3);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_rd.push_back(rd_idx);
    endtask

    // sram wraps at its depth
    function automatic int byte_idx(input rv32i_word a);
        return int'(a[`DMEM_AW+1:0]);
    endfunction

    task automatic check_val(input string test, input string field,
                             input rv32i_word exp, input rv32i_word got);
        assert (got === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test, field, exp, got);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // compare wb fields against the model and then commit the store
    task automatic check_row(input int i);
        rv32i_word          a;
        lane_t              lane;
        logic               is_ld;
        logic               is_st;
        logic               mis;
        byte_mask_t         mask;
        byte_mask_t         exp_rmask;
        byte_mask_t         exp_wmask;
        rv32i_word          exp_data;
        rv32i_word          st_word;
        logic [15:0]        half;
        logic signed [31:0] sx;
        int                 base;
        a     = t_addr[i];
        lane  = a[1:0];
        is_ld = (t_op[i] == `OP_LOAD);
        is_st = (t_op[i] == `OP_STORE);
        // funct3 low bits give the width as byte, half or word
        case (t_f3[i][1:0])
            2'd0:    mask = 4'b0001 << lane;
            2'd1:    mask = 4'b0011 << lane;
            default: mask = 4'b1111;
        endcase
        mis = (is_ld || is_st) &&
              ((t_f3[i][1:0] == 2'd1 && lane[0]) || (t_f3[i][1:0] == 2'd2 && lane != 2'd0));
        exp_rmask = (is_ld && !mis) ? mask : 4'b0000;
        exp_wmask = (is_st && !mis) ? mask : 4'b0000;
        base = byte_idx({a[31:2], 2'b00});
        half = {mem_model[byte_idx(a + 1)], mem_model[byte_idx(a)]};
        // non-loads hand back the alu result
        exp_data = a;
        if (is_ld) begin
            case (t_f3[i])
                `F3_LB: begin
                    sx = $signed(mem_model[byte_idx(a)]);
                    exp_data = sx;
                end
                `F3_LBU: exp_data = mem_model[byte_idx(a)];
                `F3_LH: begin
                    sx = $signed(half);
                    exp_data = sx;
                end
                `F3_LHU: exp_data = half;
                default: exp_data = {mem_model[base + 3], mem_model[base + 2],
                                     mem_model[base + 1], mem_model[base]};
            endcase
        end
        check_val(t_name[i], "wb_valid", 1, wb_valid);
        check_val(t_name[i], "wb_rd", t_rd[i], wb_rd);
        check_val(t_name[i], "wb_addr", {a[31:2], 2'b00}, wb_addr);
        check_val(t_name[i], "wb_rmask", exp_rmask, wb_rmask);
        check_val(t_name[i], "wb_wmask", exp_wmask, wb_wmask);
        check_val(t_name[i], "wb_trap", mis, wb_trap);
        check_val(t_name[i], "wb_rd_we", !is_st && !mis && t_rd[i] != 0, wb_rd_we);
        if (!is_st && !mis) begin
            check_val(t_name[i], "wb_data", exp_data, wb_data);
        end
        if (exp_wmask != 4'b0000) begin
            st_word = t_data[i] << (8 * lane);
            check_val(t_name[i], "wb_mem_wdata", st_word, wb_mem_wdata);
            // only enabled lanes change
            for (int k = 0; k < 4; k++) begin
                if (exp_wmask[k]) begin
                    mem_model[base + k] = st_word[8*k +: 8];
                end
            end
        end
    endtask

    initial begin
        rv32i_word ra;
        void'($urandom(32'h984b));
        rst        = 1'b1;
        in_valid   = 1'b0;
        // a store record without valid must not strobe
        opcode     = `OP_STORE;
        funct3     = `F3_SW;
        alu_out    = '0;
        store_data = '0;
        rd         = '0;
        for (int b = 0; b < MEM_BYTES; b++) begin
            mem_model[b] = 8'h00;
        end

        // word store and load back
        add_row("sw_word", `OP_STORE, `F3_SW, 32'h100, 32'hdeadbeef, 5'd0);
        add_row("lw_word", `OP_LOAD, `F3_LW, 32'h100, 32'h0, 5'd5);
        // one byte per lane then signed and unsigned reads
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("sb_lane%0d", k), `OP_STORE, `F3_SB, 32'h200 + k,
                    {24'h5555_55, lane_bytes[k]}, 5'd0);
        end
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("lb_lane%0d", k), `OP_LOAD, `F3_LB, 32'h200 + k, 0, 5'd6);
            add_row($sformatf("lbu_lane%0d", k), `OP_LOAD, `F3_LBU, 32'h200 + k, 0, 5'd7);
        end
        // halfwords merge into an existing word
        add_row("sw_base", `OP_STORE, `F3_SW, 32'h300, 32'haabbccdd, 5'd0);
        add_row("sh_lane0", `OP_STORE, `F3_SH, 32'h300, 32'h1111f00d, 5'd0);
        add_row("lw_merge0", `OP_LOAD, `F3_LW, 32'h300, 32'h0, 5'd8);
        add_row("sh_lane2", `OP_STORE, `F3_SH, 32'h302, 32'h2222_8001, 5'd0);
        add_row("lh_lane2", `OP_LOAD, `F3_LH, 32'h302, 32'h0, 5'd8);
        add_row("lhu_lane2", `OP_LOAD, `F3_LHU, 32'h302, 32'h0, 5'd8);
        add_row("lh_lane0", `OP_LOAD, `F3_LH, 32'h300, 32'h0, 5'd8);
        add_row("lhu_lane0", `OP_LOAD, `F3_LHU, 32'h300, 32'h0, 5'd8);
        // misaligned accesses trap and leave memory alone
        add_row("lh_odd", `OP_LOAD, `F3_LH, 32'h301, 32'h0, 5'd4);
        add_row("sh_odd", `OP_STORE, `F3_SH, 32'h303, 32'hffffffff, 5'd0);
        add_row("lw_mis", `OP_LOAD, `F3_LW, 32'h302, 32'h0, 5'd4);
        add_row("sw_mis", `OP_STORE, `F3_SW, 32'h101, 32'h0badf00d, 5'd0);
        add_row("lw_after_mis", `OP_LOAD, `F3_LW, 32'h300, 32'h0, 5'd4);
        add_row("lw_after_sw_mis", `OP_LOAD, `F3_LW, 32'h100, 32'h0, 5'd4);
        // alu results pass through
        add_row("op_imm", `OP_IMM, 3'b000, 32'h12345678, 32'h0, 5'd3);
        add_row("op_reg_x0", `OP_REG, 3'b000, 32'hcafef00d, 32'h0, 5'd0);
        add_row("op_reg", `OP_REG, 3'b111, 32'h0000abcd, 32'h0, 5'd31);
        // store then load of the same word on the next cycle
        add_row("sw_b2b", `OP_STORE, `F3_SW, 32'h140, 32'h01020304, 5'd0);
        add_row("lw_b2b", `OP_LOAD, `F3_LW, 32'h140, 32'h0, 5'd10);
        add_row("sb_b2b", `OP_STORE, `F3_SB, 32'h141, 32'h000000ee, 5'd0);
        add_row("lw_b2b_merge", `OP_LOAD, `F3_LW, 32'h140, 32'h0, 5'd10);
        // random pairs across the whole address space wrapping in the sram
        for (int r = 0; r < 3; r++) begin
            ra = $urandom() & 32'hffff_fffc;
            add_row("rand_sw", `OP_STORE, `F3_SW, ra, $urandom(), 5'd0);
            add_row("rand_lw", `OP_LOAD, `F3_LW, ra, 32'h0, 5'd11);
            ra = $urandom();
            add_row("rand_sb", `OP_STORE, `F3_SB, ra, $urandom(), 5'd0);
            add_row("rand_lbu", `OP_LOAD, `F3_LBU, ra, 32'h0, 5'd12);
        end
        cycle_limit = t_name.size() + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // quiet outputs out of reset
        check_val("reset", "wb_valid", 0, wb_valid);
        check_val("reset", "wb_trap", 0, wb_trap);
        check_val("reset", "wb_rd_we", 0, wb_rd_we);
        check_val("reset", "dmem_write", 0, uut.dmem_bus.write);

        // row i checked one cycle later as row i+1 goes in
        for (int i = 0; i < t_name.size(); i++) begin
            in_valid   = 1'b1;
            opcode     = t_op[i];
            funct3     = t_f3[i];
            alu_out    = t_addr[i];
            store_data = t_data[i];
            rd         = t_rd[i];
            @(negedge clk);
            check_row(i);
        end
        // a load record without valid must not strobe
        in_valid = 1'b0;
        opcode   = `OP_LOAD;
        funct3   = `F3_LW;
        @(negedge clk);
        check_val("drain", "wb_valid", 0, wb_valid);
        check_val("drain", "dmem_read", 0, uut.dmem_bus.read);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/rv32i_types_pkg.sv
design/dmem_if.sv
design/mem_stage.sv
design/data_sram.sv
design/mem_wb_reg.sv
design/load_align.sv
design/mem_subsys_top.sv
tb/mem_subsys_chk.sv
tb/mem_subsys_tb.sv
